//--- alu_data_pkg.sv
`default_nettype none

package alu_data_pkg;

    // ----------------------------------------
    // Operand widths
    // ----------------------------------------

    // Full word of the 8086 data path.
    localparam int word_w = 16;

    // Half-carry is taken at the nibble boundary.
    localparam int nibble_w = 4;

    // One operand or result word.
    typedef logic [word_w-1:0] word_t;

    // Low byte lane, used in byte mode.
    typedef logic [word_w/2-1:0] byte_t;

    // Bit number for the single-bit operations.
    typedef logic [3:0] bit_index_t;

    // ----------------------------------------
    // Flag vector
    // ----------------------------------------

    // Six status flags, one bit each.
    typedef logic [5:0] flag_vec_t;

    // Bit positions inside flag_vec_t.
    localparam int flag_cy = 0;
    localparam int flag_ac = 1;
    localparam int flag_v  = 2;
    localparam int flag_p  = 3;
    localparam int flag_s  = 4;
    localparam int flag_z  = 5;

endpackage

`default_nettype wire

//--- alu_op_pkg.sv
`default_nettype none

package alu_op_pkg;

    // Operation codes; values above op_not1 are invalid.
    typedef enum logic [4:0] {
        op_add   = 5'd0,
        op_addc  = 5'd1,
        op_inc   = 5'd2,
        op_sub   = 5'd3,
        op_subc  = 5'd4,
        op_cmp   = 5'd5,
        op_dec   = 5'd6,
        op_neg   = 5'd7,
        op_and   = 5'd8,
        op_or    = 5'd9,
        op_xor   = 5'd10,
        op_not   = 5'd11,
        op_set1  = 5'd12,
        op_clr1  = 5'd13,
        op_test1 = 5'd14,
        op_not1  = 5'd15
    } alu_op_e;

    // Which unit supplies the retired result.
    typedef enum logic {
        unit_arith = 1'b0,
        unit_logic = 1'b1
    } unit_sel_e;

    // One bit per flag, set where the operation writes that flag.
    typedef logic [5:0] flag_mask_t;

endpackage

`default_nettype wire

//--- alu_issue.sv
`timescale 1ns/1ps
`default_nettype none

module alu_issue (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    ce,
    input  wire logic                    execute,
    input  wire alu_op_pkg::alu_op_e     operation,
    input  wire alu_data_pkg::word_t     ta,
    input  wire alu_data_pkg::word_t     tb,
    input  wire logic                    wide,
    input  wire alu_data_pkg::flag_vec_t flags_in,
    output logic                         s1_valid,
    output alu_op_pkg::alu_op_e          s1_op,
    output alu_data_pkg::word_t          s1_a,
    output alu_data_pkg::word_t          s1_b_eff,
    output logic                         s1_wide,
    output alu_data_pkg::flag_vec_t      s1_flags,
    output alu_op_pkg::unit_sel_e        s1_unit,
    output alu_op_pkg::flag_mask_t       s1_mask
);
    import alu_data_pkg::*;
    import alu_op_pkg::*;

    // Single-flag masks.
    localparam flag_mask_t m_cy = flag_mask_t'(1) << flag_cy;
    localparam flag_mask_t m_ac = flag_mask_t'(1) << flag_ac;
    localparam flag_mask_t m_v  = flag_mask_t'(1) << flag_v;
    localparam flag_mask_t m_z  = flag_mask_t'(1) << flag_z;
    // P, S and Z together.
    localparam flag_mask_t m_psz = m_z | (flag_mask_t'(1) << flag_p) | (flag_mask_t'(1) << flag_s);
    localparam flag_mask_t m_all = m_psz | m_cy | m_ac | m_v;

    logic       op_ok;
    unit_sel_e  unit;
    flag_mask_t mask;
    word_t      b_eff;

    // ----------------------------------------
    // Decode
    // ----------------------------------------
    always_comb begin
        op_ok = 1'b1;
        unit  = unit_arith;
        mask  = m_all;
        b_eff = tb;
        case (operation)
            op_add, op_sub, op_cmp, op_neg: ;
            // Carry-in folded into the second operand.
            op_addc, op_subc: b_eff = tb + word_t'(flags_in[flag_cy]);
            // inc and dec keep the incoming CY.
            op_inc, op_dec: begin
                b_eff = word_t'(1);
                mask  = m_all & ~m_cy;
            end
            op_and, op_or, op_xor: unit = unit_logic;
            op_test1: begin
                unit = unit_logic;
                mask = m_cy | m_v | m_z;
            end
            // No flags written.
            op_not, op_set1, op_clr1, op_not1: begin
                unit = unit_logic;
                mask = '0;
            end
            default: op_ok = 1'b0;
        endcase
    end

    // ----------------------------------------
    // Stage one registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else if (ce) begin
            s1_valid <= execute & op_ok;
        end
    end

    // Payload is only loaded when an operation is accepted.
    always_ff @(posedge clk) begin
        if (ce && execute) begin
            s1_op    <= operation;
            s1_a     <= ta;
            s1_b_eff <= b_eff;
            s1_wide  <= wide;
            s1_flags <= flags_in;
            s1_unit  <= unit;
            s1_mask  <= mask;
        end
    end

endmodule

`default_nettype wire

//--- alu_arith.sv
`timescale 1ns/1ps
`default_nettype none

module alu_arith (
    input  wire alu_op_pkg::alu_op_e  s1_op,
    input  wire alu_data_pkg::word_t  s1_a,
    input  wire alu_data_pkg::word_t  s1_b_eff,
    input  wire logic                 s1_wide,
    output alu_data_pkg::word_t       arith_result,
    output alu_data_pkg::flag_vec_t   arith_flags
);
    import alu_data_pkg::*;
    import alu_op_pkg::*;

    localparam int byte_w = $bits(byte_t);

    logic              is_sub;
    word_t             op_x;
    word_t             op_y;
    logic [word_w:0]   raw;
    logic              carry_out;
    logic              half_carry;
    logic              x_sign;
    logic              y_sign;
    logic              r_sign;
    logic              ovf;

    // ----------------------------------------
    // Operand steering
    // ----------------------------------------
    always_comb begin
        is_sub = s1_op inside {op_sub, op_subc, op_cmp, op_dec, op_neg};
        // Negate runs as 0 - ta.
        if (s1_op == op_neg) begin
            op_x = '0;
            op_y = s1_a;
        end else begin
            op_x = s1_a;
            op_y = s1_b_eff;
        end
    end

    // 17-bit sum or difference.
    assign raw = is_sub ? {1'b0, op_x} - {1'b0, op_y}
                        : {1'b0, op_x} + {1'b0, op_y};

    assign arith_result = raw[word_w-1:0];

    // ----------------------------------------
    // Flags
    // ----------------------------------------

    // Carry into bit k is x[k] ^ y[k] ^ raw[k], for add and subtract alike.
    // In byte mode that gives the carry or borrow out of bit 7.
    assign carry_out = s1_wide ? raw[word_w]
                               : op_x[byte_w] ^ op_y[byte_w] ^ raw[byte_w];

    // Carry or borrow out of bit 3.
    assign half_carry = op_x[nibble_w] ^ op_y[nibble_w] ^ raw[nibble_w];

    // Sign bits at the selected width.
    assign x_sign = s1_wide ? op_x[word_w-1] : op_x[byte_w-1];
    assign y_sign = s1_wide ? op_y[word_w-1] : op_y[byte_w-1];
    assign r_sign = s1_wide ? raw[word_w-1]  : raw[byte_w-1];

    // Signed overflow.
    // For neg this is set only for 8000h or 80h.
    assign ovf = is_sub ? (x_sign ^ y_sign) & (x_sign ^ r_sign)
                        : (x_sign ^ r_sign) & (y_sign ^ r_sign);

    always_comb begin
        arith_flags          = '0;
        arith_flags[flag_cy] = carry_out;
        arith_flags[flag_ac] = half_carry;
        arith_flags[flag_v]  = ovf;
    end

endmodule

`default_nettype wire

//--- alu_logic_bit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_logic_bit (
    input  wire alu_op_pkg::alu_op_e  s1_op,
    input  wire alu_data_pkg::word_t  s1_a,
    input  wire alu_data_pkg::word_t  s1_b_eff,
    input  wire logic                 s1_wide,
    output alu_data_pkg::word_t       logic_result,
    output alu_data_pkg::flag_vec_t   logic_flags
);
    import alu_data_pkg::*;
    import alu_op_pkg::*;

    bit_index_t bit_idx;
    word_t      bit_mask;

    // Bit index wraps to three bits in byte mode.
    assign bit_idx  = s1_wide ? s1_b_eff[3:0] : {1'b0, s1_b_eff[2:0]};
    assign bit_mask = word_t'(1) << bit_idx;

    // ----------------------------------------
    // Result
    // ----------------------------------------
    always_comb begin
        case (s1_op)
            op_and:   logic_result = s1_a & s1_b_eff;
            op_or:    logic_result = s1_a | s1_b_eff;
            op_xor:   logic_result = s1_a ^ s1_b_eff;
            op_not:   logic_result = ~s1_a;
            op_set1:  logic_result = s1_a | bit_mask;
            op_clr1:  logic_result = s1_a & ~bit_mask;
            // Only the tested bit survives, so Z shows its state.
            op_test1: logic_result = s1_a & bit_mask;
            op_not1:  logic_result = s1_a ^ bit_mask;
            default:  logic_result = s1_a;
        endcase
    end

    // CY, AC and V are cleared wherever this unit writes them.
    // P, S and Z come from retire.
    assign logic_flags = '0;

endmodule

`default_nettype wire

//--- alu_retire.sv
`timescale 1ns/1ps
`default_nettype none

module alu_retire (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    ce,
    input  wire logic                    s1_valid,
    input  wire alu_op_pkg::alu_op_e     s1_op,
    input  wire logic                    s1_wide,
    input  wire alu_data_pkg::flag_vec_t s1_flags,
    input  wire alu_op_pkg::unit_sel_e   s1_unit,
    input  wire alu_op_pkg::flag_mask_t  s1_mask,
    input  wire alu_data_pkg::word_t     arith_result,
    input  wire alu_data_pkg::flag_vec_t arith_flags,
    input  wire alu_data_pkg::word_t     logic_result,
    input  wire alu_data_pkg::flag_vec_t logic_flags,
    output alu_data_pkg::word_t          result,
    output alu_data_pkg::flag_vec_t      flags,
    output logic                         done
);
    import alu_data_pkg::*;
    import alu_op_pkg::*;

    word_t     unit_res;
    word_t     res_ext;
    byte_t     low_byte;
    flag_vec_t calc;
    flag_vec_t merged;

    // ----------------------------------------
    // Result select and flag merge
    // ----------------------------------------
    always_comb begin
        unit_res = (s1_unit == unit_logic) ? logic_result : arith_result;
        low_byte = unit_res[$bits(byte_t)-1:0];
        // Byte mode result is zero-extended.
        res_ext  = s1_wide ? unit_res : word_t'(low_byte);

        calc         = (s1_unit == unit_logic) ? logic_flags : arith_flags;
        // Parity is the XOR of the low byte only.
        calc[flag_p] = ^low_byte;
        calc[flag_s] = s1_wide ? unit_res[word_w-1] : low_byte[$bits(byte_t)-1];
        calc[flag_z] = (res_ext == '0);

        // Unwritten flags pass through.
        merged = (calc & s1_mask) | (s1_flags & ~s1_mask);
    end

    // ----------------------------------------
    // Output registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else if (ce) begin
            done <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ce && s1_valid) begin
            flags <= merged;
            // cmp leaves the previous result in place.
            if (s1_op != op_cmp) begin
                result <= res_ext;
            end
        end
    end

endmodule

`default_nettype wire

//--- alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module alu_core (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    ce,
    input  wire logic                    execute,
    input  wire alu_op_pkg::alu_op_e     operation,
    input  wire alu_data_pkg::word_t     ta,
    input  wire alu_data_pkg::word_t     tb,
    input  wire logic                    wide,
    input  wire alu_data_pkg::flag_vec_t flags_in,
    output alu_data_pkg::word_t          result,
    output alu_data_pkg::flag_vec_t      flags,
    output logic                         done,
    output logic                         busy
);
    import alu_data_pkg::*;
    import alu_op_pkg::*;

    // Stage one.
    logic       s1_valid;
    logic       s1_wide;
    alu_op_e    s1_op;
    word_t      s1_a;
    word_t      s1_b_eff;
    flag_vec_t  s1_flags;
    unit_sel_e  s1_unit;
    flag_mask_t s1_mask;

    // Unit outputs.
    word_t      arith_result;
    flag_vec_t  arith_flags;
    word_t      logic_result;
    flag_vec_t  logic_flags;

    // ----------------------------------------
    // Pipeline
    // ----------------------------------------
    alu_issue issue_i (
        .clk      (clk),
        .reset    (reset),
        .ce       (ce),
        .execute  (execute),
        .operation(operation),
        .ta       (ta),
        .tb       (tb),
        .wide     (wide),
        .flags_in (flags_in),
        .s1_valid (s1_valid),
        .s1_op    (s1_op),
        .s1_a     (s1_a),
        .s1_b_eff (s1_b_eff),
        .s1_wide  (s1_wide),
        .s1_flags (s1_flags),
        .s1_unit  (s1_unit),
        .s1_mask  (s1_mask)
    );

    alu_arith arith_i (
        .s1_op       (s1_op),
        .s1_a        (s1_a),
        .s1_b_eff    (s1_b_eff),
        .s1_wide     (s1_wide),
        .arith_result(arith_result),
        .arith_flags (arith_flags)
    );

    alu_logic_bit logic_i (
        .s1_op       (s1_op),
        .s1_a        (s1_a),
        .s1_b_eff    (s1_b_eff),
        .s1_wide     (s1_wide),
        .logic_result(logic_result),
        .logic_flags (logic_flags)
    );

    alu_retire retire_i (
        .clk         (clk),
        .reset       (reset),
        .ce          (ce),
        .s1_valid    (s1_valid),
        .s1_op       (s1_op),
        .s1_wide     (s1_wide),
        .s1_flags    (s1_flags),
        .s1_unit     (s1_unit),
        .s1_mask     (s1_mask),
        .arith_result(arith_result),
        .arith_flags (arith_flags),
        .logic_result(logic_result),
        .logic_flags (logic_flags),
        .result      (result),
        .flags       (flags),
        .done        (done)
    );

    // done doubles as the stage two valid bit.
    assign busy = execute | s1_valid | done;

endmodule

`default_nettype wire

//--- alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_tb;
    import alu_data_pkg::*;
    import alu_op_pkg::*;

    // Edges allowed between issue and done.
    localparam int wait_limit = 20;

    logic      clk;
    logic      reset;
    logic      ce;
    logic      execute;
    alu_op_e   operation;
    word_t     ta;
    word_t     tb;
    logic      wide;
    flag_vec_t flags_in;
    word_t     result;
    flag_vec_t flags;
    logic      done;
    logic      busy;

    // Stimulus table, one entry per index.
    string     names[$];
    alu_op_e   ops[$];
    word_t     tas[$];
    word_t     tbs[$];
    logic      wides[$];
    flag_vec_t fins[$];
    word_t     res_q[$];
    flag_vec_t fls[$];

    logic [31:0] rng;
    int          checks_done;

    alu_core dut_i (
        .clk      (clk),
        .reset    (reset),
        .ce       (ce),
        .execute  (execute),
        .operation(operation),
        .ta       (ta),
        .tb       (tb),
        .wide     (wide),
        .flags_in (flags_in),
        .result   (result),
        .flags    (flags),
        .done     (done),
        .busy     (busy)
    );

    // 100 ns clock.
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks_done++;
        if (exp !== act) begin
            abort_run($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_flags(input string name, input flag_vec_t exp, input flag_vec_t act);
        checks_done++;
        if (exp !== act) begin
            abort_run($sformatf("mismatch %s: expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks_done++;
        if (exp !== act) begin
            abort_run($sformatf("mismatch %s: expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks_done++;
        if (exp != act) begin
            abort_run($sformatf("mismatch %s: expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic add_case(input string name, input alu_op_e op, input word_t a, input word_t b,
                            input logic w, input flag_vec_t fin, input word_t res,
                            input flag_vec_t fl);
        names.push_back(name);
        ops.push_back(op);
        tas.push_back(a);
        tbs.push_back(b);
        wides.push_back(w);
        fins.push_back(fin);
        res_q.push_back(res);
        fls.push_back(fl);
    endtask

    // Columns are name, op, ta, tb, wide, flags_in, result, flags.
    // Flag literals read z s p v ac cy from the left.
    task automatic load_table();
        add_case("add_w_cy", op_add, 16'hFFFF, 16'h1, 1, 6'b000000, 16'h0, 6'b100011);
        add_case("add_b_ovf", op_add, 16'h7F, 16'h1, 0, 6'b000000, 16'h80, 6'b011110);
        add_case("add_b_cy", op_add, 16'h12F0, 16'h3420, 0, 6'b000000, 16'h10, 6'b001001);
        add_case("addc_w", op_addc, 16'hF, 16'h0, 1, 6'b000001, 16'h10, 6'b001010);
        add_case("addc_b", op_addc, 16'hFF, 16'h0, 0, 6'b000001, 16'h0, 6'b100011);
        add_case("inc_w", op_inc, 16'h7FFF, 16'h0, 1, 6'b000001, 16'h8000, 6'b010111);
        // A byte carry out that must not reach CY.
        add_case("inc_b", op_inc, 16'h12FF, 16'h0, 0, 6'b000000, 16'h0, 6'b100010);
        add_case("sub_w_bw", op_sub, 16'h3, 16'h5, 1, 6'b000000, 16'hFFFE, 6'b011011);
        add_case("sub_b_ovf", op_sub, 16'h80, 16'h1, 0, 6'b000000, 16'h7F, 6'b001110);
        // Result stays at the previous value.
        add_case("cmp_w", op_cmp, 16'h3, 16'h7, 1, 6'b000000, 16'h7F, 6'b010011);
        add_case("subc_b", op_subc, 16'h10, 16'hF, 0, 6'b000001, 16'h0, 6'b100000);
        add_case("subc_w", op_subc, 16'h0, 16'h7FFF, 1, 6'b000001, 16'h8000, 6'b010101);
        // A borrow out that must not reach CY.
        add_case("dec_b", op_dec, 16'h0, 16'h0, 0, 6'b000000, 16'hFF, 6'b010010);
        add_case("dec_w", op_dec, 16'h8000, 16'h0, 1, 6'b000001, 16'h7FFF, 6'b000111);
        add_case("neg_w", op_neg, 16'h1, 16'h0, 1, 6'b000000, 16'hFFFF, 6'b010011);
        add_case("neg_b_80", op_neg, 16'h80, 16'h0, 0, 6'b000000, 16'h80, 6'b011101);
        add_case("and_w", op_and, 16'hF0F0, 16'hFF00, 1, 6'b000111, 16'hF000, 6'b010000);
        add_case("or_b", op_or, 16'h1203, 16'h3480, 0, 6'b000111, 16'h83, 6'b011000);
        add_case("xor_w", op_xor, 16'hA5A5, 16'hA5A5, 1, 6'b000101, 16'h0, 6'b100000);
        add_case("not_b", op_not, 16'h1234, 16'h0, 0, 6'b010101, 16'hCB, 6'b010101);
        // Byte index 11 wraps to bit 3.
        add_case("set1_b", op_set1, 16'h0, 16'hB, 0, 6'b001001, 16'h8, 6'b001001);
        add_case("clr1_b", op_clr1, 16'hFF, 16'h9, 0, 6'b000010, 16'hFD, 6'b000010);
        // test1 keeps only the tested bit.
        add_case("test1_w", op_test1, 16'h400, 16'hA, 1, 6'b011111, 16'h400, 6'b011010);
        add_case("test1_b", op_test1, 16'h1, 16'hE, 0, 6'b000111, 16'h0, 6'b100010);
        add_case("not1_b", op_not1, 16'h0, 16'hF, 0, 6'b000000, 16'h80, 6'b000000);
    endtask

    // Call right after a rising edge.
    task automatic drive_case(input int i);
        execute   <= 1'b1;
        operation <= ops[i];
        ta        <= tas[i];
        tb        <= tbs[i];
        wide      <= wides[i];
        flags_in  <= fins[i];
    endtask

    task automatic check_outputs(input int i);
        check_word(names[i], res_q[i], result);
        check_flags(names[i], fls[i], flags);
    endtask

    // ----------------------------------------
    // One operation with random ce stalls
    // ----------------------------------------
    task automatic run_single(input int i);
        int   edges;
        int   active;
        logic seen;
        edges  = 0;
        active = 0;
        seen   = 1'b0;
        @(posedge clk);
        ce <= 1'b1;
        drive_case(i);
        while (!seen) begin
            @(posedge clk);
            edges++;
            // ce as seen by the DUT at this edge.
            if (ce) active++;
            execute <= 1'b0;
            rng = xorshift32(rng);
            ce <= (rng[1:0] != 2'd0);
            @(negedge clk);
            if (done) begin
                seen = 1'b1;
            end else begin
                check_bit({names[i], " busy"}, 1'b1, busy);
                if (edges >= wait_limit) abort_run({"done never arrived for ", names[i]});
            end
        end
        // Frozen edges only stretch the wait.
        check_count({names[i], " active edges"}, 2, active);
        check_outputs(i);
    endtask

    // An operation code outside the enum is dropped.
    task automatic run_invalid(input word_t last_res, input flag_vec_t last_fl);
        @(posedge clk);
        ce        <= 1'b1;
        execute   <= 1'b1;
        operation <= alu_op_e'(5'd20);
        repeat (3) begin
            @(posedge clk);
            execute <= 1'b0;
            @(negedge clk);
            check_bit("invalid done", 1'b0, done);
            check_bit("invalid busy", 1'b0, busy);
        end
        check_word("invalid result", last_res, result);
        check_flags("invalid flags", last_fl, flags);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int n;
        reset       <= 1'b1;
        ce          <= 1'b1;
        execute     <= 1'b0;
        operation   <= op_add;
        ta          <= '0;
        tb          <= '0;
        wide        <= 1'b1;
        flags_in    <= '0;
        rng         = 32'd62828;
        checks_done = 0;
        load_table();
        n = names.size();

        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit("reset done", 1'b0, done);
        check_bit("reset busy", 1'b0, busy);

        for (int i = 0; i < n; i++) begin
            run_single(i);
        end

        // Back to back, one issue per cycle.
        @(posedge clk);
        ce      <= 1'b1;
        execute <= 1'b0;
        for (int j = 0; j <= n + 2; j++) begin
            @(posedge clk);
            if (j < n) begin
                drive_case(j);
            end else begin
                execute <= 1'b0;
            end
            @(negedge clk);
            // Entry j-2 lands two edges after its issue.
            if (j >= 2 && j < n + 2) begin
                check_bit({names[j-2], " done"}, 1'b1, done);
                check_outputs(j - 2);
            end
            check_bit("pipeline busy", (j < n + 2), busy);
        end
        check_bit("drained done", 1'b0, done);

        run_invalid(res_q[n-1], fls[n-1]);

        if (checks_done > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("no checks were run");
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
alu_data_pkg.sv
alu_op_pkg.sv
alu_issue.sv
alu_arith.sv
alu_logic_bit.sv
alu_retire.sv
alu_core.sv
alu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TB_TOP    ?= alu_tb
RTL_TOP   ?= alu_core
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/1ps
PASS_MSG  ?= === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
